//--- ica_error_pkg.sv
package ica_error_pkg;

    // weight word and matrix shape.
    localparam int W_WIDTH  = 26;
    localparam int NUM_ROWS = 4;
    localparam int NUM_COLS = 4;

    // one signed Q-format weight.
    typedef logic signed [W_WIDTH-1:0] weight_t;

    // full 4x4 weight matrix, 416 bits, row major.
    typedef weight_t [NUM_ROWS-1:0][NUM_COLS-1:0] weight_mat_t;

    // most positive and most negative weights.
    localparam weight_t W_MAX = {1'b0, {(W_WIDTH-1){1'b1}}};
    localparam weight_t W_MIN = {1'b1, {(W_WIDTH-1){1'b0}}};

    // an element has converged when its magnitude change is below this.
    localparam weight_t ERR_THRESH = 26'h0000400;

    // number of stage enables issued per iteration.
    localparam int NUM_STAGES = 4;

    // sequencer states, one per pipeline stage plus idle.
    typedef enum logic [2:0] {
        ST_IDLE = 3'd0,
        ST_ABS  = 3'd1,
        ST_SUB  = 3'd2,
        ST_ABS3 = 3'd3,
        ST_OUT  = 3'd4
    } err_state_t;

endpackage

//--- error_controller.sv
`timescale 1ns/100ps

module error_controller (
    input  logic clk_error,
    input  logic rst,
    input  logic en_error,
    output logic error_busy,
    output logic en_abs,
    output logic en_sub,
    output logic en_abs3,
    output logic en_out
);
    import ica_error_pkg::*;

    err_state_t state;
    err_state_t state_nxt;
    logic       start_ok;

    // a start only counts while the sequencer is idle.
    assign start_ok = en_error && (state == ST_IDLE);

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (start_ok) begin
                    state_nxt = ST_ABS;
                end
            end
            ST_ABS: begin
                state_nxt = ST_SUB;
            end
            ST_SUB: begin
                state_nxt = ST_ABS3;
            end
            ST_ABS3: begin
                state_nxt = ST_OUT;
            end
            ST_OUT: begin
                state_nxt = ST_IDLE;
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_error) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // one enable per busy state.
    assign en_abs  = (state == ST_ABS);
    assign en_sub  = (state == ST_SUB);
    assign en_abs3 = (state == ST_ABS3);
    assign en_out  = (state == ST_OUT);

    // busy covers all NUM_STAGES enable cycles.
    assign error_busy = (state != ST_IDLE);

endmodule

//--- error_abs.sv
`timescale 1ns/100ps

module error_abs (
    input  logic                      clk_error,
    input  logic                      rst,
    input  logic                      en_abs,
    input  ica_error_pkg::weight_mat_t i,
    output ica_error_pkg::weight_mat_t o
);
    import ica_error_pkg::*;

    weight_mat_t abs_val;

    // element-wise magnitude, most negative input clips to W_MAX.
    always_comb begin
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int c = 0; c < NUM_COLS; c++) begin
                weight_t e;
                e = i[r][c];
                if (e == W_MIN) begin
                    abs_val[r][c] = W_MAX;
                end else if (e < 0) begin
                    abs_val[r][c] = -e;
                end else begin
                    abs_val[r][c] = e;
                end
            end
        end
    end

    always_ff @(posedge clk_error) begin
        if (rst) begin
            o <= '0;
        end else if (en_abs) begin
            o <= abs_val;
        end
    end

endmodule

//--- error_diff.sv
`timescale 1ns/100ps

module error_diff (
    input  logic                      clk_error,
    input  logic                      rst,
    input  logic                      en_sub,
    input  logic                      en_abs3,
    input  ica_error_pkg::weight_mat_t mag_new,
    input  ica_error_pkg::weight_mat_t mag_old,
    output ica_error_pkg::weight_mat_t o
);
    import ica_error_pkg::*;

    weight_mat_t diff_val;
    weight_mat_t diff_q;

    // both magnitudes are non-negative, so the difference cannot overflow.
    always_comb begin
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int c = 0; c < NUM_COLS; c++) begin
                diff_val[r][c] = mag_new[r][c] - mag_old[r][c];
            end
        end
    end

    always_ff @(posedge clk_error) begin
        if (rst) begin
            diff_q <= '0;
        end else if (en_sub) begin
            diff_q <= diff_val;
        end
    end

    // magnitude of the change, loaded one cycle after the subtraction.
    error_abs abs_diff_i (
        .clk_error (clk_error),
        .rst       (rst),
        .en_abs    (en_abs3),
        .i         (diff_q),
        .o         (o)
    );

endmodule

//--- error_out.sv
`timescale 1ns/100ps

module error_out (
    input  logic                      clk_error,
    input  logic                      rst,
    input  logic                      en_out,
    input  ica_error_pkg::weight_mat_t w_new,
    input  ica_error_pkg::weight_mat_t diff_mag,
    output ica_error_pkg::weight_mat_t w,
    output logic                      is_converge
);
    import ica_error_pkg::*;

    logic [NUM_ROWS-1:0][NUM_COLS-1:0] below;
    logic                              all_below;

    // strict compare, a change equal to the threshold does not converge.
    always_comb begin
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int c = 0; c < NUM_COLS; c++) begin
                below[r][c] = (diff_mag[r][c] < ERR_THRESH);
            end
        end
    end

    assign all_below = &below;

    // the accepted matrix becomes the reference for the next iteration.
    always_ff @(posedge clk_error) begin
        if (rst) begin
            w           <= '0;
            is_converge <= 1'b0;
        end else if (en_out) begin
            w           <= w_new;
            is_converge <= all_below;
        end
    end

endmodule

//--- error_cal.sv
`timescale 1ns/100ps

module error_cal (
    input  logic                      clk_error,
    input  logic                      rst,
    input  logic                      en_error,
    input  ica_error_pkg::weight_mat_t w_new,
    output ica_error_pkg::weight_mat_t w,
    output logic                      is_converge,
    output logic                      error_busy
);
    import ica_error_pkg::*;

    logic        en_abs;
    logic        en_sub;
    logic        en_abs3;
    logic        en_out;

    weight_mat_t mag_new;
    weight_mat_t mag_old;
    weight_mat_t diff_mag;

    error_controller ctrl_i (
        .clk_error  (clk_error),
        .rst        (rst),
        .en_error   (en_error),
        .error_busy (error_busy),
        .en_abs     (en_abs),
        .en_sub     (en_sub),
        .en_abs3    (en_abs3),
        .en_out     (en_out)
    );

    // magnitudes of the incoming and the stored matrix, same enable.
    error_abs abs_new_i (
        .clk_error (clk_error),
        .rst       (rst),
        .en_abs    (en_abs),
        .i         (w_new),
        .o         (mag_new)
    );

    error_abs abs_old_i (
        .clk_error (clk_error),
        .rst       (rst),
        .en_abs    (en_abs),
        .i         (w),
        .o         (mag_old)
    );

    error_diff diff_i (
        .clk_error (clk_error),
        .rst       (rst),
        .en_sub    (en_sub),
        .en_abs3   (en_abs3),
        .mag_new   (mag_new),
        .mag_old   (mag_old),
        .o         (diff_mag)
    );

    // stored weights loop back into abs_old_i.
    error_out out_i (
        .clk_error   (clk_error),
        .rst         (rst),
        .en_out      (en_out),
        .w_new       (w_new),
        .diff_mag    (diff_mag),
        .w           (w),
        .is_converge (is_converge)
    );

endmodule

//--- error_cal_chk.sv
`timescale 1ns/100ps

module error_cal_chk (
    input logic clk_error,
    input logic rst,
    input logic en_error,
    input logic error_busy,
    input logic en_abs,
    input logic en_sub,
    input logic en_abs3,
    input logic en_out
);

    // the sequencer never overlaps two stages.
    assert property (@(posedge clk_error) disable iff (rst)
        $onehot0({en_abs, en_sub, en_abs3, en_out}))
        else $error("more than one stage enable high");

    // fixed four cycle busy window after an accepted start.
    assert property (@(posedge clk_error) disable iff (rst)
        (en_error && !error_busy) |=>
            error_busy ##1 error_busy ##1 error_busy ##1 error_busy ##1 !error_busy)
        else $error("busy window after start is not four cycles");

    assert property (@(posedge clk_error) disable iff (rst)
        en_out |-> error_busy)
        else $error("en_out outside busy window");

    // enables stay quiet through reset.
    assert property (@(posedge clk_error)
        (rst && $past(rst)) |-> !(en_abs || en_sub || en_abs3 || en_out))
        else $error("stage enable high during reset");

endmodule

bind error_cal error_cal_chk chk_i (
    .clk_error  (clk_error),
    .rst        (rst),
    .en_error   (en_error),
    .error_busy (error_busy),
    .en_abs     (en_abs),
    .en_sub     (en_sub),
    .en_abs3    (en_abs3),
    .en_out     (en_out)
);

//--- error_cal_tb.sv
`timescale 1ns/100ps

module error_cal_tb;
    import ica_error_pkg::*;

    logic        clk_error;
    logic        rst;
    logic        en_error;
    weight_mat_t w_new;
    weight_mat_t w;
    logic        is_converge;
    logic        error_busy;

    weight_mat_t mats[$];
    bit          flags[$];
    integer      seed;
    integer      cycle_cnt;
    integer      cycle_limit;

    error_cal dut_i (
        .clk_error   (clk_error),
        .rst         (rst),
        .en_error    (en_error),
        .w_new       (w_new),
        .w           (w),
        .is_converge (is_converge),
        .error_busy  (error_busy)
    );

    initial begin
        clk_error = 1'b0;
    end

    always #2 clk_error = ~clk_error;

    // run length guard, armed once the trace is loaded.
    always @(posedge clk_error) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Test FAILED");
            $fatal(1);
        end
    end

    task automatic check_val(input string name, input logic [415:0] act,
                             input logic [415:0] exp);
        if (act !== exp) begin
            $display("[ERROR] %s actual=%0h expected=%0h", name, act, exp);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    function automatic weight_t magnitude(input weight_t x);
        if (x == W_MIN) begin
            return W_MAX;
        end
        return (x < 0) ? -x : x;
    endfunction

    // reference convergence rule over all sixteen elements.
    function automatic bit expect_converge(input weight_mat_t nw, input weight_mat_t old);
        bit      ok;
        weight_t d;
        ok = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int c = 0; c < NUM_COLS; c++) begin
                d = magnitude(nw[r][c]) - magnitude(old[r][c]);
                if (magnitude(d) >= ERR_THRESH) begin
                    ok = 1'b0;
                end
            end
        end
        return ok;
    endfunction

    task automatic load_trace();
        integer      fd;
        integer      r;
        integer      cnt;
        string       line;
        logic [25:0] v [16];
        logic        f;
        weight_mat_t m;
        fd = $fopen("error_cal_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file error_cal_trace.txt");
            $display("Test FAILED");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            line = "";
            r = $fgets(line, fd);
            if (r != 0 && line.len() > 1 && line.getc(0) != "#") begin
                cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                              v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8],
                              v[9], v[10], v[11], v[12], v[13], v[14], v[15], f);
                if (cnt != 17) begin
                    $display("malformed trace line: %s", line);
                    $display("Test FAILED");
                    $fatal(1);
                end
                for (int k = 0; k < 16; k++) begin
                    m[k/4][k%4] = v[k];
                end
                mats.push_back(m);
                flags.push_back(f);
            end
        end
        $fclose(fd);
    endtask

    task automatic run_iter(input int idx, input bit stray);
        int n;
        w_new    = mats[idx];
        en_error = 1'b1;
        @(posedge clk_error);
        #1;
        en_error = 1'b0;
        check_val("error_busy", error_busy, 1);
        n = 0;
        while (error_busy) begin
            // a start while busy must be dropped.
            en_error = (stray && n == 1);
            @(posedge clk_error);
            #1;
            n = n + 1;
        end
        en_error = 1'b0;
        check_val("busy_cycles", n, 4);
        check_val("w", w, mats[idx]);
        check_val("is_converge", is_converge, flags[idx]);
        if (stray) begin
            @(posedge clk_error);
            #1;
            check_val("error_busy", error_busy, 0);
        end
    endtask

    initial begin
        weight_mat_t prev;
        int          gap;
        seed        = 32'h4b701c18;
        cycle_cnt   = 0;
        cycle_limit = 0;
        rst         = 1'b1;
        en_error    = 1'b0;
        w_new       = '0;

        load_trace();
        cycle_limit = 10 * mats.size() + 50;

        // trace flags must agree with the convergence rule.
        prev = '0;
        for (int i = 0; i < mats.size(); i++) begin
            if (expect_converge(mats[i], prev) != flags[i]) begin
                $display("trace line %0d has a flag that disagrees with the rule", i);
                $display("Test FAILED");
                $fatal(1);
            end
            prev = mats[i];
        end

        repeat (4) @(posedge clk_error);
        #1;
        rst = 1'b0;
        check_val("error_busy", error_busy, 0);
        check_val("is_converge", is_converge, 0);
        check_val("w", w, 0);

        for (int i = 0; i < mats.size(); i++) begin
            run_iter(i, (i % 3) == 1);
            gap = $random(seed) & 32'h3;
            repeat (gap) begin
                @(posedge clk_error);
                #1;
            end
        end

        $display("Test OK");
        $finish;
    end

endmodule

//--- error_cal_trace.txt
# columns: sixteen hex weights w[0][0] w[0][1] ... w[3][3], row major, 26 bit two's complement
# last column: expected is_converge after the iteration, previous matrix starts at zero
0100000 0200000 0300000 0400000 0500000 0600000 0700000 0800000 0900000 0a00000 0b00000 0c00000 0d00000 0e00000 0f00000 1000000 0
0100000 0200000 0300000 0400000 0500000 0600000 0700000 0800000 0900000 0a00000 0b00000 0c00000 0d00000 0e00000 0f00000 1000000 1
0100000 0200000 0300000 0400000 0500000 0600000 0700000 0800000 0900000 0a00000 0b00000 0c00000 0d00000 0e00000 0f00000 1000000 1
0100400 0200000 0300000 0400000 0500000 0600000 0700000 0800000 0900000 0a00000 0b00000 0c00000 0d00000 0e00000 0f00000 1000000 0
0100400 0200000 0300000 0400000 0500000 0600000 0700000 0800000 0900000 0a00000 0b00000 0c00000 0d00000 0e00000 0f00000 1000000 1
01007ff 0200000 0300000 0400000 0500000 0600000 0700000 0800000 0900000 0a00000 0b00000 0c00000 0d00000 0e00000 0f00000 1000000 1
3eff801 0200000 0300000 0400000 0500000 0600000 0700000 0800000 0900000 0a00000 0b00000 0c00000 0d00000 0e00000 0f00000 1000000 1
3eff801 3e00000 3d00000 3c00000 3b00000 3a00000 3900000 3800000 3700000 3600000 3500000 3400000 3300000 3200000 3100000 3000000 1
01007ff 0200000 0300000 0400000 0500000 0600000 0700000 0800000 0900000 0a00000 0b00000 0c00000 0d00000 0e00000 0f00000 1000000 1
0100000 0200000 0300000 0400000 0500000 0600000 0700000 0800000 0900000 0a00000 0b00000 0c00000 0d00000 0e00000 0f00000 1000000 0
0100000 0200000 0300000 0400000 0500000 0600000 0700000 0800000 0900000 0a00000 0b00000 0c00000 0d00000 0e00000 0f00000 10003ff 1
0100000 0200000 0300000 0400000 0500000 0600000 0700000 0800000 0900000 0a00000 0b00000 0c00000 0d00000 0e00000 0f00000 1000000 1
0100000 0200000 0300000 0400000 0500000 0600400 0700000 0800000 0900000 0a00000 0b00000 0c00000 0d00000 0e00000 0f00000 1000000 0
0100000 0200000 0300000 0400000 0500000 0600000 0700000 0800000 0900000 0a00000 0b00000 0c00000 0d00000 0e00000 0f00000 1000000 0
2000000 0200000 0300000 0400000 0500000 0600000 0700000 0800000 0900000 0a00000 0b00000 0c00000 0d00000 0e00000 0f00000 1000000 0
1ffffff 0200000 0300000 0400000 0500000 0600000 0700000 0800000 0900000 0a00000 0b00000 0c00000 0d00000 0e00000 0f00000 1000000 1
2000000 0200000 0300000 0400000 0500000 0600000 0700000 0800000 0900000 0a00000 0b00000 0c00000 0d00000 0e00000 0f00000 1000000 1
2000001 0200000 0300000 0400000 0500000 0600000 0700000 0800000 0900000 0a00000 0b00000 0c00000 0d00000 0e00000 0f00000 1000000 1
0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0
0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 1
00003ff 00003ff 00003ff 00003ff 00003ff 00003ff 00003ff 00003ff 00003ff 00003ff 00003ff 00003ff 00003ff 00003ff 00003ff 00003ff 1
3fffc01 3fffc01 3fffc01 3fffc01 3fffc01 3fffc01 3fffc01 3fffc01 3fffc01 3fffc01 3fffc01 3fffc01 3fffc01 3fffc01 3fffc01 3fffc01 1
0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 0000000 1
0000400 0000400 0000400 0000400 0000400 0000400 0000400 0000400 0000400 0000400 0000400 0000400 0000400 0000400 0000400 0000400 0
0000001 0000001 0000001 0000001 0000001 0000001 0000001 0000001 0000001 0000001 0000001 0000001 0000001 0000001 0000001 0000001 1
0100000 0200000 0300000 0400000 0500000 0600000 0700000 0800000 0900000 0a00000 0b00000 0c00000 0d00000 0e00000 0f00000 1000000 0
0100000 0200000 0300000 0400000 0500000 0600000 0700000 0800000 0900000 0a00000 0b00000 0c00000 0d00000 0e00000 0f00000 1000000 1
3f00000 3e00000 3d00000 3c00000 3b00000 3a00000 3900000 3800000 3700000 3600000 3500000 3400000 3300000 3200000 3100000 3000000 1
0100000 0200000 0300000 0400000 0500000 0600000 0700000 0800000 0900000 0a00000 0b00000 0c00000 0d00000 0e00000 0f00000 1000000 1
0100000 0200000 0300000 0400000 0500000 0600000 0700000 0800000 0900000 0a00000 0afffff 0c00000 0d00000 0e00000 0f00000 1000000 1
0100000 0200000 0300000 0400000 0500000 0600000 0700000 0800000 0900000 0a00000 0b00400 0c00000 0d00000 0e00000 0f00000 1000000 0
0100000 0200000 0300000 0400000 0500000 0600000 0700000 0800000 0900000 0a00000 0b00000 0c00000 0d00000 0e00000 0f00000 1000000 0
0100000 0200000 0300000 0400000 0500000 0600000 0700000 0800000 0900000 0a00000 0b00000 0c00000 0d00000 0e00000 0f00000 1000000 1

//--- project.f
ica_error_pkg.sv
error_controller.sv
error_abs.sv
error_diff.sv
error_out.sv
error_cal.sv
error_cal_chk.sv
error_cal_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
LINT      = --lint-only -Wall --timing
TOP       = error_cal_tb
RTL_TOP   = error_cal
FILELIST  = project.f
LOG       = sim.log
OBJ       = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	-./$(OBJ)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then echo "simulation did not complete"; exit 1; fi

lint:
	$(VERILATOR) $(LINT) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ) $(LOG)
